// File: list.f
+incdir+include
source/armOpPkg.sv
source/execBusPkg.sv
source/condUnit.sv
source/barrelShifter.sv
source/dataAlu.sv
source/execControl.sv
source/executeStage.sv
tb/executeStage_properties.sv
tb/executeStage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= executeStage_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
FILE_LIST ?= list.f
PASS_MSG  ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) include/exec_config.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/executeStage_testdata.txt
# cond opcode setFlags operandA operandB shift shiftAmount result writeEnable flags
# all hex; shift 0 LSL 1 LSR 2 ASR 3 ROR; flags are NZCV
e 4 1 00000001 00000002 0 00 00000003 1 0
e 4 1 ffffffff 00000001 0 00 00000000 1 6
e 5 1 00000010 00000020 0 00 00000031 1 0  # ADC takes C from line above
e 4 1 7fffffff 00000001 0 00 80000000 1 9
e 2 1 00000003 00000005 0 00 fffffffe 1 8
e 6 1 00000010 00000003 0 00 0000000c 1 2
e 6 1 00000010 00000003 0 00 0000000d 1 2
e 3 1 00000005 00000014 0 00 0000000f 1 2
e 7 1 00000014 00000005 0 00 fffffff1 1 8
e 2 1 80000000 00000001 0 00 7fffffff 1 3
e d 1 00000000 80000001 0 01 00000002 1 3
e d 1 00000000 80000001 1 00 00000000 1 7  # LSR 32
e d 1 00000000 80000000 2 00 ffffffff 1 b  # ASR 32
e d 1 00000000 00000002 3 00 80000001 1 9  # RRX
e c 1 00000100 000000f0 1 04 0000010f 1 1
e 1 1 ffffffff 80000010 2 05 03ffffff 1 3
e e 1 ffffffff 0000000f 3 04 0fffffff 1 3
e a 1 00000005 00000005 0 00 00000000 0 6
e b 1 7fffffff 7fffffff 0 00 fffffffe 0 9
e 8 1 000000f0 0000000f 0 00 00000000 0 5
e 9 1 80000000 00000000 0 00 80000000 0 9
0 4 1 00000000 00000000 0 00 00000000 0 9  # EQ fails, flags kept
1 4 0 00000010 00000001 0 00 00000011 1 9
2 d 1 00000000 12345678 0 00 12345678 0 9
3 d 0 00000000 0000abcd 0 00 0000abcd 1 9
4 4 0 00000001 00000002 0 00 00000003 1 9
5 4 0 00000001 00000002 0 00 00000003 0 9
6 2 0 00000009 00000004 0 00 00000005 1 9
7 2 0 00000009 00000004 0 00 00000005 0 9
8 c 0 000000f0 0000000f 0 00 000000ff 0 9
9 c 0 000000f0 0000000f 0 00 000000ff 1 9
a 1 0 000000ff 0000000f 0 00 000000f0 1 9
b 1 0 000000ff 0000000f 0 00 000000f0 0 9
c 0 0 000000ff 0000003c 0 00 0000003c 1 9
d 0 0 000000ff 0000003c 0 00 0000003c 0 9
f 4 1 00000000 00000000 0 00 00000000 0 9  # NV never executes
e a 1 00000008 00000003 0 00 00000005 0 2
8 d 0 00000000 00000077 0 00 00000077 1 2
0 2 1 00000001 00000002 0 00 ffffffff 0 2
7 f 1 00000000 00000000 3 00 7fffffff 1 0  # RRX of zero with C set

// File: tb/executeStage_tb.sv
`include "exec_config.svh"

module executeStage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk;
  logic                   reset;
  logic                   opValid;
  execBusPkg::execOp      op;
  logic                   resultValid;
  execBusPkg::stageResult out;
  execBusPkg::nzcvFlags   flags;

  // One entry per data line
  execBusPkg::execOp           stimOps[$];
  logic [`EXEC_DATA_WIDTH-1:0] expResult[$];
  logic                        expWrite[$];
  execBusPkg::nzcvFlags        expFlags[$];

  int   errorCount;
  int   checkCount;
  int   lineCount;
  logic loaded;  // Watchdog waits for the op count

  executeStage DUT (.clk, .reset, .opValid, .op, .resultValid, .out, .flags);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic loadTestData();
    int                fd;
    string             line;
    int                fields;
    logic [31:0]       fCond, fOpc, fSet, fA, fB, fShift, fAmt, fRes, fWe, fFlags;
    execBusPkg::execOp cur;
    fd = $fopen("tb/executeStage_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/executeStage_testdata.txt for reading");
      errorCount++;
    end else begin
      while (!$feof(fd)) begin
        // Comment and blank lines skipped
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fCond, fOpc, fSet,
                           fA, fB, fShift, fAmt, fRes, fWe, fFlags);
          if (fields != 10) begin
            $display("Test data line could not be read: %s", line);
            errorCount++;
          end else begin
            cur.cond        = armOpPkg::condCode'(fCond[3:0]);
            cur.opcode      = armOpPkg::dpOpcode'(fOpc[3:0]);
            cur.setFlags    = fSet[0];
            cur.operandA    = fA;
            cur.operandB    = fB;
            cur.shift       = armOpPkg::shiftType'(fShift[1:0]);
            cur.shiftAmount = fAmt[`EXEC_SHAMT_WIDTH-1:0];
            stimOps.push_back(cur);
            expResult.push_back(fRes);
            expWrite.push_back(fWe[0]);
            expFlags.push_back(execBusPkg::nzcvFlags'(fFlags[3:0]));
          end
        end
      end
      $fclose(fd);
    end
    lineCount = stimOps.size();
  endtask

  task automatic checkReset();
    checkCount++;
    if (resultValid !== 1'b0 || out.writeEnable !== 1'b0 || flags !== 4'b0000) begin
      $display("Error at %0t: after reset resultValid %b writeEnable %b flags %b",
               $time, resultValid, out.writeEnable, flags);
      errorCount++;
    end
  endtask

  // One cycle after the strobe
  task automatic checkStrobe(input int idx);
    checkCount++;
    if (resultValid !== 1'b1) begin
      $display("No resultValid one cycle after op %0d was issued", idx + 1);
      errorCount++;
    end
    if (out.result !== expResult[idx]) begin
      $display("Error at %0t: op %0d result %h, expected %h",
               $time, idx + 1, out.result, expResult[idx]);
      errorCount++;
    end
    if (out.writeEnable !== expWrite[idx]) begin
      $display("Error at %0t: op %0d writeEnable %b, expected %b",
               $time, idx + 1, out.writeEnable, expWrite[idx]);
      errorCount++;
    end
    if (flags !== expFlags[idx]) begin
      $display("Error at %0t: op %0d flags %b, expected %b",
               $time, idx + 1, flags, expFlags[idx]);
      errorCount++;
    end
  endtask

  task automatic checkIdle(input int idx);
    checkCount++;
    if (resultValid !== 1'b0) begin
      $display("Error at %0t: resultValid high in idle cycle after op %0d", $time, idx + 1);
      errorCount++;
    end
    if (out.result !== expResult[idx] || out.writeEnable !== expWrite[idx] ||
        flags !== expFlags[idx]) begin
      $display("Error at %0t: out or flags moved in idle cycle after op %0d", $time, idx + 1);
      errorCount++;
    end
  endtask

  initial begin
    int unsigned gap;
    reset      = 1'b1;
    opValid    = 1'b0;
    op         = '0;
    errorCount = 0;
    checkCount = 0;
    lineCount  = 0;
    loaded     = 1'b0;
    void'($urandom(32'hfa44));
    loadTestData();
    loaded = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    checkReset();
    for (int i = 0; i < lineCount; i++) begin
      opValid = 1'b1;
      op      = stimOps[i];
      @(negedge clk);
      opValid     = 1'b0;
      op.operandA = $urandom();  // Junk operands while idle
      op.operandB = $urandom();
      checkStrobe(i);
      gap = $urandom_range(3);
      repeat (gap) begin
        @(negedge clk);
        checkIdle(i);
      end
    end
    $display("Summary: %0d ops, %0d checks, %0d errors", lineCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Worst case five cycles per op plus reset
  initial begin
    wait (loaded === 1'b1);
    repeat (lineCount * 5 + 40) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", lineCount * 5 + 40);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: tb/executeStage_properties.sv
module executeStage_properties (
  input logic                   clk,
  input logic                   reset,
  input logic                   opValid,
  input execBusPkg::execOp      op,
  input logic                   resultValid,
  input execBusPkg::stageResult out,
  input execBusPkg::nzcvFlags   flags
);
  timeunit 1ns;
  timeprecision 100ps;

  logic isCompare;  // TST, TEQ, CMP, CMN

  assign isCompare = (op.opcode == armOpPkg::TST) | (op.opcode == armOpPkg::TEQ) |
                     (op.opcode == armOpPkg::CMP) | (op.opcode == armOpPkg::CMN);

  // Exactly one cycle of latency
  validFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
    resultValid == $past(opValid))
    else $error("resultValid does not follow opValid by one cycle");

  // Flags move only on the edge that raises resultValid
  flagsHoldWhenIdle: assert property (@(posedge clk) disable iff (reset)
    !resultValid |-> $stable(flags))
    else $error("flags changed without a result");

  compareNeverWrites: assert property (@(posedge clk) disable iff (reset)
    (opValid && isCompare) |=> !out.writeEnable)
    else $error("compare or test op raised writeEnable");

  // Cleared one edge after reset is seen
  outputsZeroInReset: assert property (@(posedge clk)
    reset |=> (!resultValid && out == '0 && flags == '0))
    else $error("outputs not cleared by reset");

endmodule

bind executeStage executeStage_properties properties (
  .clk(clk), .reset(reset), .opValid(opValid), .op(op),
  .resultValid(resultValid), .out(out), .flags(flags)
);

// File: source/executeStage.sv
`include "exec_config.svh"

module executeStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   opValid,
  input  execBusPkg::execOp      op,
  output logic                   resultValid,
  output execBusPkg::stageResult out,
  output execBusPkg::nzcvFlags   flags
);

  execBusPkg::aluCtrl          aluControl;
  armOpPkg::flagClass          flagClass;
  logic                        flagsWrite;
  logic                        condEx;
  execBusPkg::nzcvFlags        flagsNext;
  execBusPkg::nzcvFlags        aluFlags;
  logic [`EXEC_DATA_WIDTH-1:0] shifted;       // Second operand after shift
  logic                        shifterCarry;
  logic [`EXEC_DATA_WIDTH-1:0] aluResult;

  execControl control (
    .clk, .reset, .opValid,
    .opcode     (op.opcode),
    .setFlags   (op.setFlags),
    .condEx, .flagsNext, .aluResult, .aluControl, .flagClass, .flagsWrite,
    .flags, .resultValid, .out
  );

  barrelShifter shifter (
    .operand     (op.operandB),
    .shift       (op.shift),
    .shiftAmount (op.shiftAmount),
    .carryIn     (flags.carry),   // Stored C for LSL 0 and RRX
    .shifted,
    .carryOut    (shifterCarry)
  );

  dataAlu alu (
    .a        (op.operandA),
    .b        (shifted),
    .ctrl     (aluControl),
    .carryIn  (flags.carry),
    .result   (aluResult),
    .aluFlags
  );

  condUnit condition (
    .cond (op.cond),
    .flags, .aluFlags, .shifterCarry, .flagsWrite, .flagClass, .condEx, .flagsNext
  );

endmodule

// File: source/execControl.sv
`include "exec_config.svh"

module execControl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        opValid,     // One-cycle issue strobe
  input  armOpPkg::dpOpcode           opcode,
  input  logic                        setFlags,
  input  logic                        condEx,
  input  execBusPkg::nzcvFlags        flagsNext,
  input  logic [`EXEC_DATA_WIDTH-1:0] aluResult,
  output execBusPkg::aluCtrl          aluControl,
  output armOpPkg::flagClass          flagClass,
  output logic                        flagsWrite,
  output execBusPkg::nzcvFlags        flags,       // Flag register
  output logic                        resultValid,
  output execBusPkg::stageResult      out
);

  // Opcode decode
  always_comb begin
    aluControl.opcode     = opcode;
    aluControl.useCarryIn = 1'b0;
    aluControl.invertA    = 1'b0;
    aluControl.invertB    = 1'b0;
    aluControl.writesReg  = 1'b1;
    flagClass             = armOpPkg::flagArith;
    case (opcode)
      armOpPkg::SUB: aluControl.invertB = 1'b1;     // a + ~b + 1
      armOpPkg::RSB: aluControl.invertA = 1'b1;     // ~a + b + 1
      armOpPkg::ADD: ;
      armOpPkg::ADC: aluControl.useCarryIn = 1'b1;
      armOpPkg::SBC: begin
        aluControl.invertB    = 1'b1;
        aluControl.useCarryIn = 1'b1;
      end
      armOpPkg::RSC: begin
        aluControl.invertA    = 1'b1;
        aluControl.useCarryIn = 1'b1;
      end
      armOpPkg::CMP: begin                          // SUB without write
        aluControl.invertB   = 1'b1;
        aluControl.writesReg = 1'b0;
      end
      armOpPkg::CMN: aluControl.writesReg = 1'b0;   // ADD without write
      armOpPkg::TST, armOpPkg::TEQ: begin
        aluControl.writesReg = 1'b0;
        flagClass            = armOpPkg::flagLogical;
      end
      default: flagClass = armOpPkg::flagLogical;   // AND EOR ORR MOV BIC MVN
    endcase
  end

  // Flags only move on a valid op with S set
  assign flagsWrite = setFlags & opValid;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags       <= '0;
      resultValid <= 1'b0;
      out         <= '0;
    end else begin
      resultValid <= opValid;
      if (opValid) begin
        flags           <= flagsNext;  // Equals stored flags if not updated
        out.result      <= aluResult;
        out.writeEnable <= condEx & aluControl.writesReg;
      end
    end
  end

endmodule

// File: source/dataAlu.sv
`include "exec_config.svh"

module dataAlu (
  input  logic [`EXEC_DATA_WIDTH-1:0] a,
  input  logic [`EXEC_DATA_WIDTH-1:0] b,        // Shifted second operand
  input  execBusPkg::aluCtrl          ctrl,
  input  logic                        carryIn,  // Stored C for ADC, SBC, RSC
  output logic [`EXEC_DATA_WIDTH-1:0] result,
  output execBusPkg::nzcvFlags        aluFlags
);

  localparam int W = `EXEC_DATA_WIDTH;

  logic [W-1:0] aIn;
  logic [W-1:0] bIn;
  logic         adderCarryIn;
  logic [W:0]   sumWide;        // Carry out in the top bit
  logic [W-1:0] sum;
  logic         adderOverflow;
  logic [W-1:0] logicResult;
  logic         isArith;

  // Optional inversion turns the adder into any of the subtracts
  assign aIn = ctrl.invertA ? ~a : a;
  assign bIn = ctrl.invertB ? ~b : b;

  // Subtracts add one unless the stored carry is used
  assign adderCarryIn = ctrl.useCarryIn ? carryIn : (ctrl.invertA | ctrl.invertB);

  assign sumWide = {1'b0, aIn} + {1'b0, bIn} + {{W{1'b0}}, adderCarryIn};
  assign sum     = sumWide[W-1:0];

  // Same-sign inputs giving a different-sign sum
  assign adderOverflow = (aIn[W-1] == bIn[W-1]) & (sum[W-1] != aIn[W-1]);

  // Logic unit for the other eight opcodes
  always_comb begin
    case (ctrl.opcode)
      armOpPkg::AND, armOpPkg::TST: logicResult = a & b;
      armOpPkg::EOR, armOpPkg::TEQ: logicResult = a ^ b;
      armOpPkg::ORR:                logicResult = a | b;
      armOpPkg::MOV:                logicResult = b;
      armOpPkg::BIC:                logicResult = a & ~b;
      armOpPkg::MVN:                logicResult = ~b;
      default:                      logicResult = '0;  // Unused by arithmetic
    endcase
  end

  always_comb begin
    case (ctrl.opcode)
      armOpPkg::SUB, armOpPkg::RSB, armOpPkg::ADD, armOpPkg::ADC,
      armOpPkg::SBC, armOpPkg::RSC, armOpPkg::CMP, armOpPkg::CMN: isArith = 1'b1;
      default: isArith = 1'b0;
    endcase
  end

  assign result = isArith ? sum : logicResult;

  assign aluFlags.neg      = result[W-1];
  assign aluFlags.zero     = (result == '0);
  assign aluFlags.carry    = sumWide[W];       // Carry means no borrow
  assign aluFlags.overflow = adderOverflow;

endmodule

// File: source/barrelShifter.sv
`include "exec_config.svh"

module barrelShifter (
  input  logic [`EXEC_DATA_WIDTH-1:0]  operand,
  input  armOpPkg::shiftType           shift,
  input  logic [`EXEC_SHAMT_WIDTH-1:0] shiftAmount,
  input  logic                         carryIn,     // Stored C flag
  output logic [`EXEC_DATA_WIDTH-1:0]  shifted,
  output logic                         carryOut     // Last bit shifted out
);

  localparam int W = `EXEC_DATA_WIDTH;

  logic         amountZero;
  logic [W:0]   lslWide;     // Carry in the top bit
  logic [W:0]   lsrWide;     // Carry in the bottom bit
  logic [W:0]   asrWide;
  logic [2*W-1:0] rorWide;   // Operand doubled for rotation

  assign amountZero = (shiftAmount == '0);

  assign lslWide = {1'b0, operand} << shiftAmount;
  assign lsrWide = {operand, 1'b0} >> shiftAmount;
  assign asrWide = $signed({operand, 1'b0}) >>> shiftAmount;
  assign rorWide = {operand, operand} >> shiftAmount;

  always_comb begin
    case (shift)
      armOpPkg::LSL: begin
        if (amountZero) begin      // Plain pass-through with C kept
          shifted  = operand;
          carryOut = carryIn;
        end else begin
          shifted  = lslWide[W-1:0];
          carryOut = lslWide[W];
        end
      end
      armOpPkg::LSR: begin
        if (amountZero) begin      // LSR #32
          shifted  = '0;
          carryOut = operand[W-1];
        end else begin
          shifted  = lsrWide[W:1];
          carryOut = lsrWide[0];
        end
      end
      armOpPkg::ASR: begin
        if (amountZero) begin      // ASR #32 with sign fill
          shifted  = {W{operand[W-1]}};
          carryOut = operand[W-1];
        end else begin
          shifted  = asrWide[W:1];
          carryOut = asrWide[0];
        end
      end
      default: begin
        if (amountZero) begin      // RRX through the carry
          shifted  = {carryIn, operand[W-1:1]};
          carryOut = operand[0];
        end else begin
          shifted  = rorWide[W-1:0];
          carryOut = rorWide[W-1];  // C is the new MSB
        end
      end
    endcase
  end

endmodule

// File: source/condUnit.sv
module condUnit (
  input  armOpPkg::condCode   cond,
  input  execBusPkg::nzcvFlags flags,        // Stored flags
  input  execBusPkg::nzcvFlags aluFlags,     // Flags from this op's ALU result
  input  logic                shifterCarry,
  input  logic                flagsWrite,    // S bit qualified by the strobe
  input  armOpPkg::flagClass  flagClass,
  output logic                condEx,
  output execBusPkg::nzcvFlags flagsNext
);

  logic ge;                   // Signed greater or equal
  logic carryNext;
  logic overflowNext;
  logic updateFlags;

  assign ge = (flags.neg == flags.overflow);

  // Condition check against the stored flags
  always_comb begin
    case (cond)
      armOpPkg::EQ: condEx = flags.zero;
      armOpPkg::NE: condEx = ~flags.zero;
      armOpPkg::CS: condEx = flags.carry;
      armOpPkg::CC: condEx = ~flags.carry;
      armOpPkg::MI: condEx = flags.neg;
      armOpPkg::PL: condEx = ~flags.neg;
      armOpPkg::VS: condEx = flags.overflow;
      armOpPkg::VC: condEx = ~flags.overflow;
      armOpPkg::HI: condEx = flags.carry & ~flags.zero;
      armOpPkg::LS: condEx = ~flags.carry | flags.zero;
      armOpPkg::GE: condEx = ge;
      armOpPkg::LT: condEx = ~ge;
      armOpPkg::GT: condEx = ~flags.zero & ge;
      armOpPkg::LE: condEx = flags.zero | ~ge;
      armOpPkg::AL: condEx = 1'b1;
      default:      condEx = 1'b0;   // NV never executes
    endcase
  end

  // Logical ops take C from the shifter and keep V
  always_comb begin
    if (flagClass == armOpPkg::flagLogical) begin
      carryNext    = shifterCarry;
      overflowNext = flags.overflow;
    end else begin
      carryNext    = aluFlags.carry;
      overflowNext = aluFlags.overflow;
    end
  end

  assign updateFlags = flagsWrite & condEx;

  // Stored flags pass through unless the op executes with S set
  always_comb begin
    flagsNext = flags;
    if (updateFlags) begin
      flagsNext.neg      = aluFlags.neg;
      flagsNext.zero     = aluFlags.zero;
      flagsNext.carry    = carryNext;
      flagsNext.overflow = overflowNext;
    end
  end

endmodule

// File: source/execBusPkg.sv
`include "exec_config.svh"

package execBusPkg;

  // Stored condition flags with N in the top bit
  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } nzcvFlags;

  // One issued data-processing micro-op
  typedef struct packed {
    armOpPkg::condCode                cond;
    armOpPkg::dpOpcode                opcode;
    logic                             setFlags;   // S bit
    logic [`EXEC_DATA_WIDTH-1:0]      operandA;   // Rn value
    logic [`EXEC_DATA_WIDTH-1:0]      operandB;   // Rm or immediate before shift
    armOpPkg::shiftType               shift;
    logic [`EXEC_SHAMT_WIDTH-1:0]     shiftAmount;
  } execOp;

  // Decoded ALU control
  typedef struct packed {
    armOpPkg::dpOpcode opcode;
    logic              useCarryIn;  // ADC, SBC, RSC
    logic              invertA;     // Reverse subtract
    logic              invertB;     // Subtract
    logic              writesReg;   // Low for compare and test
  } aluCtrl;

  // Registered stage output
  typedef struct packed {
    logic [`EXEC_DATA_WIDTH-1:0] result;
    logic                        writeEnable;
  } stageResult;

endpackage

// File: source/armOpPkg.sv
package armOpPkg;

  // Condition field in ARM encoding
  typedef enum logic [3:0] {
    EQ = 4'h0,  // Z set
    NE = 4'h1,  // Z clear
    CS = 4'h2,  // C set
    CC = 4'h3,  // C clear
    MI = 4'h4,  // Negative
    PL = 4'h5,  // Positive or zero
    VS = 4'h6,  // Overflow
    VC = 4'h7,  // No overflow
    HI = 4'h8,  // Unsigned higher
    LS = 4'h9,  // Unsigned lower or same
    GE = 4'ha,
    LT = 4'hb,
    GT = 4'hc,
    LE = 4'hd,
    AL = 4'he,  // Always
    NV = 4'hf   // Never executes here
  } condCode;

  // Data-processing opcodes in instruction encoding order
  typedef enum logic [3:0] {
    AND = 4'h0, EOR = 4'h1, SUB = 4'h2, RSB = 4'h3,
    ADD = 4'h4, ADC = 4'h5, SBC = 4'h6, RSC = 4'h7,
    TST = 4'h8, TEQ = 4'h9, CMP = 4'ha, CMN = 4'hb,
    ORR = 4'hc, MOV = 4'hd, BIC = 4'he, MVN = 4'hf
  } dpOpcode;

  // Shift applied to the second operand
  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11  // Amount 0 means RRX
  } shiftType;

  // How C and V are updated
  typedef enum logic {
    flagLogical = 1'b0,  // C from shifter and V kept
    flagArith   = 1'b1   // C and V from adder
  } flagClass;

endpackage

// File: include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width of operands and results
`define EXEC_DATA_WIDTH 32

// Immediate shift amount from 0 to 31
`define EXEC_SHAMT_WIDTH 5

`endif
